//--- common/uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// apb register offsets
`define UART_ADDR_DATA   4'h0
`define UART_ADDR_STATUS 4'h4
`define UART_ADDR_DIV    4'h8

// bit period in clock cycles
`define UART_DIV_W       16
`define UART_DEFAULT_DIV 16

`define UART_FIFO_DEPTH  4

`endif

//--- common/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // apb slave request, driven by the host
    typedef struct packed {
        logic [3:0]  paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    // apb slave response
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // one receive fifo entry
    typedef struct packed {
        logic [7:0] data;
        logic       frame_err;
    } rx_word_t;

    // first member is the msb, so tx_full lands in bit 0 of STATUS
    typedef struct packed {
        logic rx_overflow;
        logic frame_err_seen;
        logic rx_full;
        logic rx_empty;
        logic tx_empty;
        logic tx_full;
    } uart_status_t;

endpackage

`default_nettype wire

//--- hw/uart_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module uart_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  wire logic     clk,
    input  wire logic     nRst,
    input  wire logic     push,
    input  wire payload_t wdata,
    output logic          full,
    input  wire logic     pop,
    output payload_t      rdata,
    output logic          empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            do_push;
    logic            do_pop;

    assign full    = (count == CW'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // head entry is visible whenever the fifo holds data
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count unchanged
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_tx (
    input  wire logic                   clk,
    input  wire logic                   nRst,
    input  wire logic [`UART_DIV_W-1:0] divisor,
    input  wire logic                   byte_valid,
    input  wire logic [7:0]             byte_data,
    output logic                        byte_pop,
    output logic                        tx_serial
);

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        START = 2'd1,
        DATA  = 2'd2,
        STOP  = 2'd3
    } tx_state_t;

    tx_state_t              state, next_state;
    logic [`UART_DIV_W-1:0] clk_count;
    logic [2:0]             bit_index;
    logic [7:0]             byte_q;
    logic [`UART_DIV_W-1:0] div_q;
    logic                   bit_done;

    assign bit_done = (clk_count == div_q - 1'b1);
    assign byte_pop = (state == IDLE) && byte_valid;

    // byte and bit period held for the whole frame
    always_ff @(posedge clk) begin
        if (byte_pop) begin
            byte_q <= byte_data;
            div_q  <= divisor;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                tx_serial = 1'b1;
                if (byte_valid) begin
                    next_state = START;
                end
            end
            START: begin
                tx_serial = 1'b0;
                if (bit_done) begin
                    next_state = DATA;
                end
            end
            DATA: begin
                tx_serial = byte_q[bit_index];
                if (bit_done && bit_index == 3'd7) begin
                    next_state = STOP;
                end
            end
            default: begin
                tx_serial = 1'b1;
                if (bit_done) begin
                    next_state = IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state     <= IDLE;
            clk_count <= '0;
            bit_index <= '0;
        end else begin
            state <= next_state;
            if (state == IDLE || bit_done) begin
                clk_count <= '0;
            end else begin
                clk_count <= clk_count + 1'b1;
            end
            // lsb first, index wraps back to 0 after bit 7
            if (state == DATA && bit_done) begin
                bit_index <= bit_index + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_rx (
    input  wire logic                   clk,
    input  wire logic                   nRst,
    input  wire logic [`UART_DIV_W-1:0] divisor,
    input  wire logic                   rx_serial,
    output logic                        word_push,
    output uart_pkg::rx_word_t          word
);

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        START     = 3'd1,
        DATA      = 3'd2,
        STOP      = 3'd3,
        WAIT_HIGH = 3'd4
    } rx_state_t;

    rx_state_t              state;
    logic                   rx_meta;
    logic                   rx_sync;
    logic                   rx_prev;
    logic [`UART_DIV_W-1:0] clk_count;
    logic [`UART_DIV_W-1:0] div_q;
    logic [2:0]             bit_index;
    logic [7:0]             shift_q;
    logic                   fall_edge;
    logic                   half_done;
    logic                   bit_done;

    assign fall_edge = rx_prev && !rx_sync;
    assign half_done = (clk_count == (div_q >> 1) - 1'b1);
    assign bit_done  = (clk_count == div_q - 1'b1);

    // word is pushed as the stop bit is sampled
    assign word_push      = (state == STOP) && bit_done;
    assign word.data      = shift_q;
    assign word.frame_err = !rx_sync;

    // two flop synchroniser plus one stage for edge detect
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_serial;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && fall_edge) begin
            div_q <= divisor;
        end
        if (state == DATA && bit_done) begin
            shift_q <= {rx_sync, shift_q[7:1]};
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state     <= IDLE;
            clk_count <= '0;
            bit_index <= '0;
        end else begin
            clk_count <= clk_count + 1'b1;
            case (state)
                IDLE: begin
                    clk_count <= '0;
                    bit_index <= '0;
                    if (fall_edge) begin
                        state <= START;
                    end
                end
                START: begin
                    // line must still be low at mid start bit
                    if (half_done) begin
                        clk_count <= '0;
                        state     <= rx_sync ? IDLE : DATA;
                    end
                end
                DATA: begin
                    if (bit_done) begin
                        clk_count <= '0;
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == 3'd7) begin
                            state <= STOP;
                        end
                    end
                end
                STOP: begin
                    if (bit_done) begin
                        clk_count <= '0;
                        state     <= rx_sync ? IDLE : WAIT_HIGH;
                    end
                end
                default: begin
                    clk_count <= '0;
                    if (rx_sync) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/uart_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_apb_regs (
    input  wire logic                   clk,
    input  wire logic                   nRst,
    input  wire uart_pkg::apb_req_t     apb_req,
    output uart_pkg::apb_rsp_t          apb_rsp,
    output logic                        tx_push,
    output logic [7:0]                  tx_data,
    input  wire logic                   tx_full,
    input  wire logic                   tx_empty,
    output logic                        rx_pop,
    input  wire uart_pkg::rx_word_t     rx_word,
    input  wire logic                   rx_empty,
    input  wire logic                   rx_full,
    input  wire logic                   rx_push,
    output logic [`UART_DIV_W-1:0]      divisor
);

    uart_pkg::uart_status_t status;
    logic                   access;
    logic                   wr;
    logic                   rd;
    logic                   sel_data;
    logic                   sel_status;
    logic                   sel_div;
    logic                   frame_err_seen;
    logic                   rx_overflow;
    logic [`UART_DIV_W-1:0] div_wdata;

    // ACCESS phase of a transfer
    assign access     = apb_req.psel && apb_req.penable;
    assign wr         = access && apb_req.pwrite;
    assign rd         = access && !apb_req.pwrite;
    assign sel_data   = (apb_req.paddr == `UART_ADDR_DATA);
    assign sel_status = (apb_req.paddr == `UART_ADDR_STATUS);
    assign sel_div    = (apb_req.paddr == `UART_ADDR_DIV);

    // fifo strobes
    assign tx_push = wr && sel_data && !tx_full;
    assign tx_data = apb_req.pwdata[7:0];
    assign rx_pop  = rd && sel_data && !rx_empty;

    assign status.rx_overflow    = rx_overflow;
    assign status.frame_err_seen = frame_err_seen;
    assign status.rx_full        = rx_full;
    assign status.rx_empty       = rx_empty;
    assign status.tx_empty       = tx_empty;
    assign status.tx_full        = tx_full;

    assign div_wdata = apb_req.pwdata[`UART_DIV_W-1:0];

    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && ((!sel_data && !sel_status && !sel_div) ||
                                     (wr && sel_data && tx_full));
        apb_rsp.prdata  = '0;
        if (rd) begin
            if (sel_data && !rx_empty) begin
                apb_rsp.prdata[8:0] = {rx_word.frame_err, rx_word.data};
            end else if (sel_status) begin
                apb_rsp.prdata[5:0] = status;
            end else if (sel_div) begin
                apb_rsp.prdata[`UART_DIV_W-1:0] = divisor;
            end
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            divisor        <= `UART_DIV_W'(`UART_DEFAULT_DIV);
            frame_err_seen <= 1'b0;
            rx_overflow    <= 1'b0;
        end else begin
            // divisor floor of 2 keeps the half-bit count nonzero
            if (wr && sel_div) begin
                divisor <= (div_wdata < `UART_DIV_W'(2)) ? `UART_DIV_W'(2) : div_wdata;
            end
            // write 1 to clear; a new event in the same cycle wins
            if (wr && sel_status && apb_req.pwdata[4]) begin
                frame_err_seen <= 1'b0;
            end
            if (wr && sel_status && apb_req.pwdata[5]) begin
                rx_overflow <= 1'b0;
            end
            // head entry carries a framing error
            if (!rx_empty && rx_word.frame_err) begin
                frame_err_seen <= 1'b1;
            end
            // receiver word dropped at a full fifo
            if (rx_push && rx_full) begin
                rx_overflow <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/uart_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_top (
    input  wire logic               clk,
    input  wire logic               nRst,
    input  wire uart_pkg::apb_req_t apb_req,
    output uart_pkg::apb_rsp_t      apb_rsp,
    output logic                    tx_serial,
    input  wire logic               rx_serial
);

    logic                   tx_push;
    logic [7:0]             tx_data;
    logic                   tx_full;
    logic                   tx_empty;
    logic                   tx_pop;
    logic [7:0]             tx_head;
    logic                   rx_push;
    uart_pkg::rx_word_t     rx_word_in;
    logic                   rx_full;
    logic                   rx_empty;
    logic                   rx_pop;
    uart_pkg::rx_word_t     rx_head;
    logic [`UART_DIV_W-1:0] divisor;

    uart_apb_regs u_regs (
        .clk      (clk),
        .nRst     (nRst),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .tx_push  (tx_push),
        .tx_data  (tx_data),
        .tx_full  (tx_full),
        .tx_empty (tx_empty),
        .rx_pop   (rx_pop),
        .rx_word  (rx_head),
        .rx_empty (rx_empty),
        .rx_full  (rx_full),
        .rx_push  (rx_push),
        .divisor  (divisor)
    );

    uart_fifo #(.payload_t(logic [7:0]), .DEPTH(`UART_FIFO_DEPTH)) u_tx_fifo (
        .clk   (clk),
        .nRst  (nRst),
        .push  (tx_push),
        .wdata (tx_data),
        .full  (tx_full),
        .pop   (tx_pop),
        .rdata (tx_head),
        .empty (tx_empty)
    );

    uart_fifo #(.payload_t(uart_pkg::rx_word_t), .DEPTH(`UART_FIFO_DEPTH)) u_rx_fifo (
        .clk   (clk),
        .nRst  (nRst),
        .push  (rx_push),
        .wdata (rx_word_in),
        .full  (rx_full),
        .pop   (rx_pop),
        .rdata (rx_head),
        .empty (rx_empty)
    );

    uart_tx u_tx (
        .clk        (clk),
        .nRst       (nRst),
        .divisor    (divisor),
        .byte_valid (!tx_empty),
        .byte_data  (tx_head),
        .byte_pop   (tx_pop),
        .tx_serial  (tx_serial)
    );

    uart_rx u_rx (
        .clk       (clk),
        .nRst      (nRst),
        .divisor   (divisor),
        .rx_serial (rx_serial),
        .word_push (rx_push),
        .word      (rx_word_in)
    );

endmodule

`default_nettype wire

//--- verif/uart_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_tb;

    localparam int CLK_PERIOD     = 40;
    localparam int NUM_FRAMES     = 23;
    localparam int MAX_DIV        = `UART_DEFAULT_DIV;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * 10 * MAX_DIV * 2 + 2000;
    localparam int TX_FULL_BIT    = 0;
    localparam int RX_EMPTY_BIT   = 2;

    logic               clk = 1'b0;
    logic               nRst;
    uart_pkg::apb_req_t apb_req;
    uart_pkg::apb_rsp_t apb_rsp;
    logic               tx_serial;
    logic               rx_serial;
    logic               inject_mode;
    logic               inj_line;

    logic [31:0] lcg_state;
    int          cur_div;
    int          cycle_count = 0;
    int          frames_sent = 0;
    int          frames_checked = 0;
    logic [7:0]  sent_q[$];
    logic [7:0]  rx_exp_q[$];
    logic [9:0]  mon_frame_q[$];
    logic [9:0]  mon_stable_q[$];
    logic [7:0]  inj_bytes[5];

    // tx loops back unless the testbench drives the line itself
    assign rx_serial = inject_mode ? inj_line : tx_serial;

    uart_top uart_top_inst (
        .clk       (clk),
        .nRst      (nRst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .tx_serial (tx_serial),
        .rx_serial (rx_serial)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_error(input string what);
        $display("error at time %0t: %s", $time, what);
        $display("Regression failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("simulation timed out after %0d cycles", cycle_count);
            $display("Regression failed");
            $fatal(1);
        end
    end

    function automatic logic [7:0] next_rand_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // start bit in bit 0, data lsb first, stop bit in bit 9
    function automatic logic [9:0] ref_frame(input logic [7:0] b);
        return {1'b1, b, 1'b0};
    endfunction

    function automatic logic [31:0] status_word(input logic tx_full, input logic tx_empty,
                                                input logic rx_empty, input logic rx_full,
                                                input logic fe_seen, input logic ovf);
        return {26'd0, ovf, fe_seen, rx_full, rx_empty, tx_empty, tx_full};
    endfunction

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
        @(negedge clk);
        apb_req.paddr   = addr;
        apb_req.pwrite  = 1'b1;
        apb_req.pwdata  = data;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #(CLK_PERIOD / 4);
        assert (apb_rsp.pready) else report_error("pready low during write");
        err = apb_rsp.pslverr;
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
        @(negedge clk);
        apb_req.paddr   = addr;
        apb_req.pwrite  = 1'b0;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #(CLK_PERIOD / 4);
        assert (apb_rsp.pready) else report_error("pready low during read");
        data = apb_rsp.prdata;
        err  = apb_rsp.pslverr;
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic check_read(input logic [3:0] addr, input logic [31:0] exp, input string what);
        logic [31:0] rd;
        logic        err;
        apb_read(addr, rd, err);
        assert (!err) else report_error({what, ": unexpected pslverr"});
        assert (rd == exp) else
            report_error($sformatf("%s: read 0x%0h, expected 0x%0h", what, rd, exp));
    endtask

    task automatic write_data_byte(input logic [7:0] b, input logic exp_err);
        logic err;
        apb_write(`UART_ADDR_DATA, {24'd0, b}, err);
        assert (err == exp_err) else
            report_error($sformatf("data write pslverr %0b, expected %0b", err, exp_err));
        if (!err) begin
            sent_q.push_back(b);
            rx_exp_q.push_back(b);
            frames_sent = frames_sent + 1;
        end
    endtask

    task automatic set_divisor(input int value);
        logic err;
        apb_write(`UART_ADDR_DIV, 32'(value), err);
        assert (!err) else report_error("divisor write gave pslverr");
        cur_div = (value < 2) ? 2 : value;
        check_read(`UART_ADDR_DIV, 32'(cur_div), "divisor read back");
    endtask

    task automatic wait_rx_word();
        logic [31:0] s;
        logic        err;
        do begin
            apb_read(`UART_ADDR_STATUS, s, err);
        end while (s[RX_EMPTY_BIT]);
    endtask

    task automatic read_loopback_word();
        logic [7:0] exp;
        wait_rx_word();
        exp = rx_exp_q.pop_front();
        check_read(`UART_ADDR_DATA, {23'd0, 1'b0, exp}, "loopback data");
    endtask

    task automatic wait_frames_done();
        while (frames_checked != frames_sent) begin
            @(posedge clk);
        end
    endtask

    task automatic loopback_burst(input int n);
        for (int i = 0; i < n; i++) begin
            write_data_byte(next_rand_byte(), 1'b0);
        end
        for (int i = 0; i < n; i++) begin
            read_loopback_word();
        end
        wait_frames_done();
    endtask

    // injected frame, stop_bit low forces a framing error
    task automatic send_frame(input logic [7:0] b, input logic stop_bit);
        logic [9:0] f;
        f    = ref_frame(b);
        f[9] = stop_bit;
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            inj_line = f[i];
            repeat (cur_div - 1) @(negedge clk);
        end
        @(negedge clk);
        inj_line = 1'b1;
        repeat (2 * cur_div) @(negedge clk);
    endtask

    // per bit, mid sample plus a flag that the line held for the whole period
    initial begin
        logic [9:0] bits;
        logic [9:0] stable;
        logic       first;
        forever begin
            @(negedge tx_serial);
            bits   = '0;
            stable = '1;
            for (int b = 0; b < 10; b++) begin
                for (int c = 0; c < cur_div; c++) begin
                    @(negedge clk);
                    if (c == 0) begin
                        first = tx_serial;
                    end else if (tx_serial != first) begin
                        stable[b] = 1'b0;
                    end
                    if (c == cur_div / 2) begin
                        bits[b] = tx_serial;
                    end
                end
            end
            mon_frame_q.push_back(bits);
            mon_stable_q.push_back(stable);
        end
    end

    initial begin
        logic [9:0] got;
        logic [9:0] stable;
        logic [9:0] exp;
        forever begin
            @(posedge clk);
            if (mon_frame_q.size() > 0) begin
                got    = mon_frame_q.pop_front();
                stable = mon_stable_q.pop_front();
                assert (sent_q.size() > 0) else report_error("frame seen with no byte written");
                exp = ref_frame(sent_q.pop_front());
                assert (got == exp) else
                    report_error($sformatf("tx frame 0x%h, expected 0x%h", got, exp));
                assert (stable == 10'h3ff) else
                    report_error($sformatf("bit period not %0d cycles", cur_div));
                frames_checked = frames_checked + 1;
            end
        end
    end

    initial begin
        logic [31:0] rd;
        logic        err;
        apb_req     = '0;
        nRst        = 1'b0;
        inject_mode = 1'b0;
        inj_line    = 1'b1;
        lcg_state   = 32'd23813;
        cur_div     = `UART_DEFAULT_DIV;
        repeat (16) @(posedge clk);
        @(negedge clk);
        nRst = 1'b1;

        // reset state
        assert (tx_serial === 1'b1) else report_error("tx_serial not high after reset");
        check_read(`UART_ADDR_STATUS, status_word(0, 1, 1, 0, 0, 0), "status after reset");
        check_read(`UART_ADDR_DIV, 32'(`UART_DEFAULT_DIV), "divisor after reset");

        // frames and loopback at the default divisor
        repeat (2) loopback_burst(4);
        check_read(`UART_ADDR_DATA, 32'd0, "read of empty rx fifo");

        set_divisor(9);
        loopback_burst(4);
        set_divisor(1);
        set_divisor(9);

        // one byte goes straight to the transmitter, four fill the fifo
        for (int i = 0; i < `UART_FIFO_DEPTH + 1; i++) begin
            write_data_byte(next_rand_byte(), 1'b0);
        end
        apb_read(`UART_ADDR_STATUS, rd, err);
        assert (rd[TX_FULL_BIT]) else report_error("tx_full not set after filling fifo");
        write_data_byte(next_rand_byte(), 1'b1);
        apb_read(4'hC, rd, err);
        assert (err) else report_error("unmapped read gave no pslverr");
        apb_write(4'hC, 32'd0, err);
        assert (err) else report_error("unmapped write gave no pslverr");
        for (int i = 0; i < `UART_FIFO_DEPTH + 1; i++) begin
            read_loopback_word();
        end
        wait_frames_done();

        // injected frames
        @(negedge clk);
        inject_mode = 1'b1;
        inj_bytes[0] = next_rand_byte();
        send_frame(inj_bytes[0], 1'b0);
        wait_rx_word();
        check_read(`UART_ADDR_DATA, {23'd0, 1'b1, inj_bytes[0]}, "frame error word");
        check_read(`UART_ADDR_STATUS, status_word(0, 1, 1, 0, 1, 0), "status after frame error");
        for (int i = 0; i < 5; i++) begin
            inj_bytes[i] = next_rand_byte();
            send_frame(inj_bytes[i], 1'b1);
        end
        check_read(`UART_ADDR_STATUS, status_word(0, 1, 0, 1, 1, 1), "status after overflow");
        apb_write(`UART_ADDR_STATUS, 32'h30, err);
        assert (!err) else report_error("status write gave pslverr");
        check_read(`UART_ADDR_STATUS, status_word(0, 1, 0, 1, 0, 0), "status after clear");
        // fifth word was dropped
        for (int i = 0; i < `UART_FIFO_DEPTH; i++) begin
            check_read(`UART_ADDR_DATA, {23'd0, 1'b0, inj_bytes[i]}, "injected data");
        end
        check_read(`UART_ADDR_STATUS, status_word(0, 1, 1, 0, 0, 0), "final status");

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- uart.f
+incdir+common
common/uart_pkg.sv
hw/uart_fifo.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_apb_regs.sv
hw/uart_top.sv
verif/uart_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the uart testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f uart.f --top-module uart_tb -o Vuart_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vuart_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

exit 0
